//--- rtl/buf_geom_pkg.sv
package buf_geom_pkg;

	// geometry defaults for the segmented buffer and the descriptor queues
	// every value here is a log2 or a bit width, never a count

	// words per segment is 2**DEF_SEGMENT_SIZE_W
	// also the width of the word offset in b_raddr
	parameter int DEF_SEGMENT_SIZE_W = 4;

	// segment number width
	// the buffer holds 2**DEF_BUF_SEG_AW segments
	parameter int DEF_BUF_SEG_AW = 6;

	// number of flows is 2**DEF_FLOWS_W
	parameter int DEF_FLOWS_W = 2;

	// descriptor slots per flow, as log2
	// the queue bank memory is flows times slots deep
	parameter int DEF_QUEUE_DEPTH_W = 4;

endpackage

//--- rtl/sched_pkg.sv
package sched_pkg;

	// walker FSM states
	// idle: no packet in progress, grant requested
	// stream: emitting the words of the current segment
	// starved: mid-packet, but the flow queue ran dry
	typedef enum logic [1:0] {
		WALK_IDLE,
		WALK_STREAM,
		WALK_STARVED
	} walk_state_t;

	// grant request meaning
	// req is high only in WALK_IDLE, so a new flow is picked only between packets
	// the segments of one packet always come from the same flow

	// descriptor layout, lsb first
	// [seg_aw-1:0]                segment number
	// [seg_aw+size_w-1:seg_aw]    offset of the last word in the segment
	// [seg_aw+size_w]             end of packet
	function automatic int desc_w(input int seg_aw, input int size_w);
		return seg_aw + size_w + 1;
	endfunction

	// lsb of the end offset field
	function automatic int end_lsb(input int seg_aw);
		return seg_aw;
	endfunction

	// position of the end-of-packet bit, always the msb
	function automatic int eop_pos(input int seg_aw, input int size_w);
		return seg_aw + size_w;
	endfunction

endpackage

//--- rtl/flow_queue_if.sv
interface flow_queue_if #(
	parameter int FLOWS_W = 2,
	parameter int DESC_W = 11
);

	// one bit per flow, high when that flow has no descriptor
	logic [2**FLOWS_W-1:0] empty;

	// retire the head of pop_flow at this edge
	logic pop;
	logic [FLOWS_W-1:0] pop_flow;

	// head descriptor of pop_flow, combinational
	logic [DESC_W-1:0] head;

	// queue bank side
	modport queue_side (
		output empty,
		output head,
		input pop,
		input pop_flow
	);

	// segment walker side
	// pop only when empty[pop_flow] is low
	modport reader_side (
		input empty,
		input head,
		output pop,
		output pop_flow
	);

endinterface

//--- rtl/flow_queue_bank.sv
module flow_queue_bank #(
	parameter int SEGMENT_SIZE_W = 4,
	parameter int BUF_SEG_AW = 6,
	parameter int FLOWS_W = 2,
	parameter int QUEUE_DEPTH_W = 4
) (
	input logic clk,
	input logic rstn,
	input logic push,
	input logic [FLOWS_W-1:0] push_flow,
	input logic [sched_pkg::desc_w(BUF_SEG_AW, SEGMENT_SIZE_W)-1:0] push_desc,
	flow_queue_if.queue_side q
);

	localparam int NF = 2**FLOWS_W;
	localparam int DESC_W = sched_pkg::desc_w(BUF_SEG_AW, SEGMENT_SIZE_W);
	localparam int MEM_DEPTH = NF * (2**QUEUE_DEPTH_W);

	// flow number is the upper address part
	// each flow owns a circular region of 2**QUEUE_DEPTH_W slots
	logic [DESC_W-1:0] mem [0:MEM_DEPTH-1];

	logic [QUEUE_DEPTH_W-1:0] wr_idx [NF];
	logic [QUEUE_DEPTH_W-1:0] rd_idx [NF];
	// one extra bit so a full queue is not read as empty
	logic [QUEUE_DEPTH_W:0] count [NF];

	logic [NF-1:0] push_hit;
	logic [NF-1:0] pop_hit;

	// per-flow decode of push and pop
	always_comb begin
		for (int f = 0; f < NF; f++) begin
			push_hit[f] = push && (push_flow == FLOWS_W'(f));
			pop_hit[f] = q.pop && (q.pop_flow == FLOWS_W'(f));
			q.empty[f] = (count[f] == '0);
		end
	end

	// descriptor storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[{push_flow, wr_idx[push_flow]}] <= push_desc;
		end
	end

	// head of the flow the walker is looking at
	assign q.head = mem[{q.pop_flow, rd_idx[q.pop_flow]}];

	// indices and occupancy
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int f = 0; f < NF; f++) begin
				wr_idx[f] <= '0;
				rd_idx[f] <= '0;
				count[f] <= '0;
			end
		end else begin
			for (int f = 0; f < NF; f++) begin
				if (push_hit[f]) begin
					wr_idx[f] <= wr_idx[f] + 1'b1;
				end
				if (pop_hit[f]) begin
					rd_idx[f] <= rd_idx[f] + 1'b1;
				end
				// push and pop together leave count alone
				case ({push_hit[f], pop_hit[f]})
					2'b10: count[f] <= count[f] + 1'b1;
					2'b01: count[f] <= count[f] - 1'b1;
					default: count[f] <= count[f];
				endcase
			end
		end
	end

endmodule

//--- rtl/flow_rr_select.sv
module flow_rr_select #(
	parameter int FLOWS_W = 2
) (
	input logic clk,
	input logic rstn,
	input logic [2**FLOWS_W-1:0] empty,
	input logic req,
	input logic taken,
	output logic grant_valid,
	output logic [FLOWS_W-1:0] grant_flow
);

	localparam int NF = 2**FLOWS_W;

	// first flow looked at in the next search
	logic [FLOWS_W-1:0] rr_ptr;

	logic [FLOWS_W-1:0] cand;
	logic [FLOWS_W-1:0] pick;
	logic found;

	// scan from rr_ptr upwards
	// the add wraps by itself since NF is a power of two
	always_comb begin
		found = 1'b0;
		pick = rr_ptr;
		cand = rr_ptr;
		for (int k = 0; k < NF; k++) begin
			cand = rr_ptr + FLOWS_W'(k);
			if (!found && !empty[cand]) begin
				found = 1'b1;
				pick = cand;
			end
		end
	end

	// grant only while the walker asks
	assign grant_valid = req && found;
	assign grant_flow = pick;

	// move past the served flow
	// a flow that was just served is looked at last in the next round
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rr_ptr <= '0;
		end else if (taken) begin
			rr_ptr <= grant_flow + 1'b1;
		end
	end

endmodule

//--- rtl/segment_walker.sv
module segment_walker #(
	parameter int SEGMENT_SIZE_W = 4,
	parameter int BUF_SEG_AW = 6,
	parameter int FLOWS_W = 2
) (
	input logic clk,
	input logic rstn,

	// output word handshake
	input logic s_rready,
	output logic s_rvalid,
	output logic [BUF_SEG_AW+SEGMENT_SIZE_W-1:0] b_raddr,

	// grant path to the round-robin selector
	input logic grant_valid,
	input logic [FLOWS_W-1:0] grant_flow,
	output logic req,
	output logic taken,

	// segment return to the free pool
	output logic [BUF_SEG_AW-1:0] freed_pointer,
	output logic freed_pointer_valid,

	flow_queue_if.reader_side q
);

	localparam int DESC_W = sched_pkg::desc_w(BUF_SEG_AW, SEGMENT_SIZE_W);
	localparam int END_LSB = sched_pkg::end_lsb(BUF_SEG_AW);
	localparam int EOP_POS = sched_pkg::eop_pos(BUF_SEG_AW, SEGMENT_SIZE_W);

	sched_pkg::walk_state_t state;

	// descriptor being walked and its flow
	logic [DESC_W-1:0] cur_desc;
	logic [FLOWS_W-1:0] cur_flow;
	// word offset inside the current segment
	logic [SEGMENT_SIZE_W-1:0] offset;

	logic [BUF_SEG_AW-1:0] cur_seg;
	logic [SEGMENT_SIZE_W-1:0] cur_end;
	logic cur_eop;
	logic beat;
	logic seg_done;

	// descriptor fields
	assign cur_seg = cur_desc[BUF_SEG_AW-1:0];
	assign cur_end = cur_desc[END_LSB +: SEGMENT_SIZE_W];
	assign cur_eop = cur_desc[EOP_POS];

	// word consumed at this edge
	assign beat = s_rvalid && s_rready;
	// current word is the last of the segment
	assign seg_done = (offset == cur_end);

	// address is segment number then offset, both held in registers
	assign b_raddr = {cur_seg, offset};

	// pop decision
	// idle: take the granted flow
	// stream: chain straight into the next segment when it is already queued
	// starved: wait for the same flow to refill
	always_comb begin
		req = (state == sched_pkg::WALK_IDLE);
		q.pop = 1'b0;
		q.pop_flow = cur_flow;
		case (state)
			sched_pkg::WALK_IDLE: begin
				q.pop = grant_valid;
				q.pop_flow = grant_flow;
			end
			sched_pkg::WALK_STREAM: begin
				q.pop = beat && seg_done && !cur_eop && !q.empty[cur_flow];
			end
			sched_pkg::WALK_STARVED: begin
				q.pop = !q.empty[cur_flow];
			end
			default: begin
				q.pop = 1'b0;
			end
		endcase
	end

	// selector moves its pointer only on a grant that was used
	assign taken = req && grant_valid;

	// control state
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= sched_pkg::WALK_IDLE;
			s_rvalid <= 1'b0;
			freed_pointer_valid <= 1'b0;
			offset <= '0;
		end else begin
			freed_pointer_valid <= 1'b0;
			case (state)
				sched_pkg::WALK_STREAM: begin
					if (beat) begin
						if (seg_done) begin
							// segment fully consumed, free it next cycle
							freed_pointer_valid <= 1'b1;
							s_rvalid <= 1'b0;
							if (cur_eop) begin
								state <= sched_pkg::WALK_IDLE;
							end else begin
								state <= sched_pkg::WALK_STARVED;
							end
						end else begin
							offset <= offset + 1'b1;
						end
					end
				end
				default: begin
					state <= state;
				end
			endcase
			// a pop overrides the above
			// new segment starts at word 0 with valid already high
			if (q.pop) begin
				state <= sched_pkg::WALK_STREAM;
				s_rvalid <= 1'b1;
				offset <= '0;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (q.pop) begin
			cur_desc <= q.head;
			cur_flow <= q.pop_flow;
		end
		if (beat && seg_done) begin
			freed_pointer <= cur_seg;
		end
	end

endmodule

//--- rtl/buffer_read_multi_flow.sv
module buffer_read_multi_flow #(
	parameter int SEGMENT_SIZE_W = buf_geom_pkg::DEF_SEGMENT_SIZE_W,
	parameter int BUF_SEG_AW = buf_geom_pkg::DEF_BUF_SEG_AW,
	parameter int FLOWS_W = buf_geom_pkg::DEF_FLOWS_W,
	parameter int QUEUE_DEPTH_W = buf_geom_pkg::DEF_QUEUE_DEPTH_W
) (
	input logic clk,
	input logic rstn,

	// descriptor push, one-cycle strobe, no back-pressure
	// top bit is end of packet
	input logic [sched_pkg::desc_w(BUF_SEG_AW, SEGMENT_SIZE_W)-1:0] used_pointer,
	input logic used_pointer_valid,
	input logic [FLOWS_W-1:0] used_pointer_flow,

	// buffer read side
	input logic s_rready,
	output logic s_rvalid,
	output logic [BUF_SEG_AW+SEGMENT_SIZE_W-1:0] b_raddr,

	// segments handed back to the free pool
	output logic [BUF_SEG_AW-1:0] freed_pointer,
	output logic freed_pointer_valid
);

	localparam int DESC_W = sched_pkg::desc_w(BUF_SEG_AW, SEGMENT_SIZE_W);

	logic req;
	logic taken;
	logic grant_valid;
	logic [FLOWS_W-1:0] grant_flow;

	// queue bank to walker
	flow_queue_if #(
		.FLOWS_W(FLOWS_W),
		.DESC_W(DESC_W)
	) fq ();

	// per-flow descriptor queues
	flow_queue_bank #(
		.SEGMENT_SIZE_W(SEGMENT_SIZE_W),
		.BUF_SEG_AW(BUF_SEG_AW),
		.FLOWS_W(FLOWS_W),
		.QUEUE_DEPTH_W(QUEUE_DEPTH_W)
	) u_bank (
		.clk(clk),
		.rstn(rstn),
		.push(used_pointer_valid),
		.push_flow(used_pointer_flow),
		.push_desc(used_pointer),
		.q(fq.queue_side)
	);

	// packet-level round robin
	flow_rr_select #(
		.FLOWS_W(FLOWS_W)
	) u_rr (
		.clk(clk),
		.rstn(rstn),
		.empty(fq.empty),
		.req(req),
		.taken(taken),
		.grant_valid(grant_valid),
		.grant_flow(grant_flow)
	);

	// word-level address generation and freeing
	segment_walker #(
		.SEGMENT_SIZE_W(SEGMENT_SIZE_W),
		.BUF_SEG_AW(BUF_SEG_AW),
		.FLOWS_W(FLOWS_W)
	) u_walker (
		.clk(clk),
		.rstn(rstn),
		.s_rready(s_rready),
		.s_rvalid(s_rvalid),
		.b_raddr(b_raddr),
		.grant_valid(grant_valid),
		.grant_flow(grant_flow),
		.req(req),
		.taken(taken),
		.freed_pointer(freed_pointer),
		.freed_pointer_valid(freed_pointer_valid),
		.q(fq.reader_side)
	);

endmodule

//--- test/buffer_read_checker.sv
module buffer_read_checker #(
	parameter int SEGMENT_SIZE_W = 4,
	parameter int BUF_SEG_AW = 6
) (
	input logic clk,
	input logic rstn,
	input logic [BUF_SEG_AW+SEGMENT_SIZE_W:0] used_pointer,
	input logic used_pointer_valid,
	input logic s_rready,
	input logic s_rvalid,
	input logic [BUF_SEG_AW+SEGMENT_SIZE_W-1:0] b_raddr,
	input logic [BUF_SEG_AW-1:0] freed_pointer,
	input logic freed_pointer_valid
);

	localparam int ADDR_W = BUF_SEG_AW + SEGMENT_SIZE_W;

	// read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// outputs quiet on the cycle after any reset edge
	reset_quiet: assert property (@(posedge clk)
		!rstn |=> (!s_rvalid && !freed_pointer_valid))
		else begin
			$error("s_rvalid or freed_pointer_valid high after reset");
			fail_count++;
		end

	// stalled word holds until taken
	hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
		(s_rvalid && !s_rready) |=> (s_rvalid && b_raddr == $past(b_raddr)))
		else begin
			$error("s_rvalid or b_raddr changed while stalled");
			fail_count++;
		end

	// a free pulse needs a consumed word of that segment one cycle earlier
	free_follows_word: assert property (@(posedge clk) disable iff (!rstn)
		freed_pointer_valid |->
			($past(s_rvalid && s_rready) &&
			freed_pointer == $past(b_raddr[ADDR_W-1:SEGMENT_SIZE_W])))
		else begin
			$error("freed segment does not match the word consumed before it");
			fail_count++;
		end

	// input assumption, back to back pushes carry different descriptors
	push_desc_differs: assert property (@(posedge clk) disable iff (!rstn)
		(used_pointer_valid && $past(used_pointer_valid)) |->
			(used_pointer != $past(used_pointer)))
		else begin
			$error("same descriptor pushed in two consecutive cycles");
			fail_count++;
		end

endmodule

bind buffer_read_multi_flow buffer_read_checker #(
	.SEGMENT_SIZE_W(SEGMENT_SIZE_W),
	.BUF_SEG_AW(BUF_SEG_AW)
) chk (
	.clk(clk),
	.rstn(rstn),
	.used_pointer(used_pointer),
	.used_pointer_valid(used_pointer_valid),
	.s_rready(s_rready),
	.s_rvalid(s_rvalid),
	.b_raddr(b_raddr),
	.freed_pointer(freed_pointer),
	.freed_pointer_valid(freed_pointer_valid)
);

//--- test/tb_buffer_read.sv
module tb_buffer_read;

	localparam int SEG_W = buf_geom_pkg::DEF_SEGMENT_SIZE_W;
	localparam int SEG_AW = buf_geom_pkg::DEF_BUF_SEG_AW;
	localparam int FLOWS_W = buf_geom_pkg::DEF_FLOWS_W;
	localparam int NF = 2**FLOWS_W;
	localparam int DESC_W = SEG_AW + SEG_W + 1;
	localparam int ADDR_W = SEG_AW + SEG_W;
	// round robin batch, two packets per flow
	localparam int MAX_PKT = 2 * NF;
	// random batches stay small so no flow queue can overflow
	localparam int N_BATCH = 3;
	localparam int RAND_PKT = 5;
	// every segment at full length is the worst case
	localparam int MAX_WORDS = (2 * N_BATCH * RAND_PKT + MAX_PKT) * 3 * (2**SEG_W);
	localparam int TIMEOUT_CYCLES = MAX_WORDS * 8 + 2000;

	logic clk = 1'b0;
	logic rstn;
	logic [DESC_W-1:0] used_pointer;
	logic used_pointer_valid;
	logic [FLOWS_W-1:0] used_pointer_flow;
	logic s_rready;
	logic s_rvalid;
	logic [ADDR_W-1:0] b_raddr;
	logic [SEG_AW-1:0] freed_pointer;
	logic freed_pointer_valid;

	logic [31:0] rng;
	int err_count = 0;
	int words_checked = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int seg_ctr = 0;
	// reference round-robin pointer
	int rr_ref = 0;

	// reference word stream, final word of each segment flagged
	logic [ADDR_W-1:0] exp_addr[$];
	bit exp_last[$];
	int flow_q[NF][$];
	int pkt_flow[MAX_PKT];
	int pkt_nseg[MAX_PKT];
	int pkt_seg[MAX_PKT][3];
	int pkt_end[MAX_PKT][3];

	bit free_due = 1'b0;
	logic [SEG_AW-1:0] free_seg;

	buffer_read_multi_flow dut0 (
		.clk(clk),
		.rstn(rstn),
		.used_pointer(used_pointer),
		.used_pointer_valid(used_pointer_valid),
		.used_pointer_flow(used_pointer_flow),
		.s_rready(s_rready),
		.s_rvalid(s_rvalid),
		.b_raddr(b_raddr),
		.freed_pointer(freed_pointer),
		.freed_pointer_valid(freed_pointer_valid)
	);

	always #10 clk = ~clk;

	function automatic int next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return int'(rng[30:16]);
	endfunction

	function automatic int all_errors();
		return err_count + int'(dut0.chk.fail_count);
	endfunction

	task automatic mismatch(input string msg);
		err_count++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	task automatic report_fault(input string msg);
		err_count++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// one packet appended to the reference word stream
	task automatic append_packet(input int k);
		for (int s = 0; s < pkt_nseg[k]; s++) begin
			for (int o = 0; o <= pkt_end[k][s]; o++) begin
				exp_addr.push_back(ADDR_W'(pkt_seg[k][s] * (2**SEG_W) + o));
				exp_last.push_back(o == pkt_end[k][s]);
			end
		end
	endtask

	// ready is low while a batch is pushed, so only the first pushed
	// flow is visible at the first grant, later grants see every flow
	task automatic build_expected(input int n);
		int f;
		int k;
		bit found;
		for (int p = 0; p < n; p++) begin
			flow_q[pkt_flow[p]].push_back(p);
		end
		k = flow_q[pkt_flow[0]].pop_front();
		append_packet(k);
		rr_ref = (pkt_flow[0] + 1) % NF;
		for (int p = 1; p < n; p++) begin
			found = 1'b0;
			for (int i = 0; i < NF; i++) begin
				f = (rr_ref + i) % NF;
				if (!found && flow_q[f].size() != 0) begin
					found = 1'b1;
					k = flow_q[f].pop_front();
					append_packet(k);
					rr_ref = (f + 1) % NF;
				end
			end
		end
	endtask

	// rr_order spreads the packets over every flow, twice each
	task automatic run_batch(input int n, input bit rr_order, input bit rand_ready);
		int start;
		start = next_rand() % NF;
		for (int k = 0; k < n; k++) begin
			pkt_flow[k] = rr_order ? (start + 3 * k) % NF : next_rand() % NF;
			pkt_nseg[k] = 1 + next_rand() % 3;
			for (int s = 0; s < pkt_nseg[k]; s++) begin
				pkt_seg[k][s] = seg_ctr;
				seg_ctr = (seg_ctr + 1) % (2**SEG_AW);
				pkt_end[k][s] = next_rand() % (2**SEG_W);
			end
		end
		build_expected(n);
		for (int k = 0; k < n; k++) begin
			for (int s = 0; s < pkt_nseg[k]; s++) begin
				@(negedge clk);
				used_pointer = {s == pkt_nseg[k] - 1, SEG_W'(pkt_end[k][s]),
					SEG_AW'(pkt_seg[k][s])};
				used_pointer_flow = FLOWS_W'(pkt_flow[k]);
				used_pointer_valid = 1'b1;
			end
		end
		@(negedge clk);
		used_pointer_valid = 1'b0;
		while (exp_addr.size() != 0) begin
			s_rready = rand_ready ? rng[20] : 1'b1;
			void'(next_rand());
			@(negedge clk);
		end
		s_rready = 1'b0;
		// room for the last free pulse
		repeat (3) @(negedge clk);
	endtask

	task automatic end_test(input string name, input int errs_before, input int words_before);
		tests_run++;
		if (all_errors() != errs_before) begin
			tests_bad++;
		end
		$display("test %s: %0d words, %0d errors", name, words_checked - words_before,
			all_errors() - errs_before);
	endtask

	// word and free monitor, sampled before the edge updates the DUT
	always @(posedge clk) begin
		if (rstn) begin
			if (free_due) begin
				assert (freed_pointer_valid && freed_pointer == free_seg)
					else mismatch($sformatf("freed %0d valid %0b, expected segment %0d",
						freed_pointer, freed_pointer_valid, free_seg));
			end else begin
				assert (!freed_pointer_valid)
					else report_fault($sformatf("segment %0d freed too early or twice",
						freed_pointer));
			end
			free_due = 1'b0;
			if (s_rvalid && s_rready) begin
				assert (exp_addr.size() != 0)
					else report_fault("word consumed when none was expected");
				if (exp_addr.size() != 0) begin
					assert (b_raddr == exp_addr[0])
						else mismatch($sformatf("b_raddr %h, expected %h", b_raddr,
							exp_addr[0]));
					words_checked++;
					if (exp_last[0]) begin
						free_due = 1'b1;
						free_seg = exp_addr[0][ADDR_W-1:SEG_W];
					end
					void'(exp_addr.pop_front());
					void'(exp_last.pop_front());
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		int e0;
		int w0;
		rng = 32'hd7178fc5;
		rstn = 1'b0;
		used_pointer = '0;
		used_pointer_valid = 1'b0;
		used_pointer_flow = '0;
		s_rready = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		// idle after reset, nothing pushed
		e0 = all_errors();
		w0 = words_checked;
		repeat (10) begin
			@(negedge clk);
			assert (!s_rvalid && !freed_pointer_valid)
				else report_fault("output active with no descriptor pushed");
		end
		end_test("reset", e0, w0);

		e0 = all_errors();
		w0 = words_checked;
		for (int b = 0; b < N_BATCH; b++) begin
			run_batch(RAND_PKT, 1'b0, 1'b0);
		end
		end_test("addressing, freeing and packet order", e0, w0);

		e0 = all_errors();
		w0 = words_checked;
		run_batch(MAX_PKT, 1'b1, 1'b0);
		end_test("round robin", e0, w0);

		// random ready stalls words mid segment
		e0 = all_errors();
		w0 = words_checked;
		for (int b = 0; b < N_BATCH; b++) begin
			run_batch(RAND_PKT, 1'b0, 1'b1);
		end
		end_test("back-pressure", e0, w0);

		$display("summary: %0d tests, %0d with errors, %0d words, %0d errors",
			tests_run, tests_bad, words_checked, all_errors());
		if (all_errors() == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
rtl/buf_geom_pkg.sv
rtl/sched_pkg.sv
rtl/flow_queue_if.sv
rtl/flow_queue_bank.sv
rtl/flow_rr_select.sv
rtl/segment_walker.sv
rtl/buffer_read_multi_flow.sv
test/buffer_read_checker.sv
test/tb_buffer_read.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_buffer_read -o sim_buffer_read
out=$(./obj_dir/sim_buffer_read +verilator+error+limit+1000 || true)
echo "$out"
if echo "$out" | grep -q "^Test passed$"; then
	exit 0
fi
exit 1
